// ==== verilog/uart_macros.svh ====
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

// data bits per frame
`define UART_DATA_W 8

// parity mode of the line, 0 = even and 1 = odd
`define UART_PARITY_ODD 1'b0

// start + data + parity + stop
`define UART_FRAME_W 11

// tx_clk cycles between two sample ticks
`define UART_CLKS_PER_SAMPLE 2

// sample ticks in one bit time
`define UART_SAMPLES_PER_BIT 8

// flops in the rx line synchronizer
`define UART_SYNC_STAGES 3

`endif

// ==== verilog/uart_frame_pkg.sv ====
`include "uart_macros.svh"

package uart_frame_pkg;

	typedef logic [`UART_DATA_W-1:0] data_t;      // one payload byte

	// field view of a frame, first member is the msb
	typedef struct packed {
		logic  stop;                                // idle level, must read 1
		logic  parity;                              // over data only
		data_t data;                                // lsb goes out first
		logic  start;                               // always 0 on the line
	} frame_fld_t;

	// shift registers use raw, frame build and decode use fld
	typedef union packed {
		logic [`UART_FRAME_W-1:0] raw;              // bit 0 is the first bit on the line
		frame_fld_t               fld;
	} frame_t;

	// parity bit to send for a byte in the configured mode
	function automatic logic calc_parity(input data_t d);
		logic p;
		p = ^d;                                     // even parity bit
		return p ^ `UART_PARITY_ODD;                // inverted for odd mode
	endfunction

endpackage

// ==== verilog/uart_host_pkg.sv ====
package uart_host_pkg;

	// byte handed in by the host with i_tx_valid
	typedef struct packed {
		uart_frame_pkg::data_t data;               // byte to serialize
	} tx_req_t;

	// what the receiver reports with its valid pulse
	typedef struct packed {
		uart_frame_pkg::data_t data;               // received byte
		logic                  parity_error;       // parity bit did not match data
		logic                  frame_error;        // stop bit sampled low
	} rx_result_t;

endpackage

// ==== verilog/uart_baud_gen.sv ====
`include "uart_macros.svh"

module uart_baud_gen (
	input  logic i_tx_clk,
	input  logic i_reset_tx,
	output logic o_sample_tick,
	output logic o_bit_tick
);

	localparam int CLK_CNT_W = $clog2(`UART_CLKS_PER_SAMPLE);
	localparam int SMP_CNT_W = $clog2(`UART_SAMPLES_PER_BIT);
	localparam int BIT_CLKS  = `UART_CLKS_PER_SAMPLE * `UART_SAMPLES_PER_BIT;
	localparam logic [CLK_CNT_W-1:0] CLK_LAST = CLK_CNT_W'(`UART_CLKS_PER_SAMPLE - 1);
	localparam logic [SMP_CNT_W-1:0] SMP_LAST = SMP_CNT_W'(`UART_SAMPLES_PER_BIT - 1);

	logic [CLK_CNT_W-1:0] clk_cnt;                  // cycles inside one sample period
	logic [SMP_CNT_W-1:0] smp_cnt;                  // samples inside one bit time
	logic                 clk_wrap;                 // last cycle of a sample period

	assign clk_wrap = (clk_cnt == CLK_LAST);

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			clk_cnt       <= '0;
			smp_cnt       <= '0;
			o_sample_tick <= 1'b0;
			o_bit_tick    <= 1'b0;
		end else begin
			o_sample_tick <= clk_wrap;                              // one cycle every 2
			o_bit_tick    <= clk_wrap & (smp_cnt == SMP_LAST);      // every 8th sample
			if (clk_wrap) begin
				clk_cnt <= '0;
				if (smp_cnt == SMP_LAST) begin
					smp_cnt <= '0;
				end else begin
					smp_cnt <= smp_cnt + 1'b1;
				end
			end else begin
				clk_cnt <= clk_cnt + 1'b1;
			end
		end
	end

	// each bit tick comes back one bit time later and lands on a sample tick
	a_bit_period: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		$past(o_bit_tick, BIT_CLKS) |-> (o_bit_tick && o_sample_tick));

endmodule

// ==== verilog/uart_tx.sv ====
`include "uart_macros.svh"

module uart_tx (
	input  logic                   i_tx_clk,
	input  logic                   i_reset_tx,
	input  logic                   i_bit_tick,
	input  logic                   i_tx_valid,
	input  uart_host_pkg::tx_req_t i_tx_req,
	output logic                   o_tx_ready,
	output logic                   o_serial
);

	import uart_frame_pkg::*;

	localparam int BIT_CNT_W = $clog2(`UART_FRAME_W + 1);
	localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(`UART_FRAME_W);

	frame_t               shift_q;                  // frame still to go out, lsb next
	frame_t               frame_d;                  // frame built from the request
	logic                 busy;                     // frame accepted and not yet done
	logic [BIT_CNT_W-1:0] bit_cnt;                  // bits already put on the line
	logic                 accept;                   // valid/ready handshake
	logic                 shift_en;                 // bit boundary during a frame

	assign o_tx_ready = ~busy;
	assign accept     = i_tx_valid & o_tx_ready;
	assign shift_en   = busy & i_bit_tick;

	always_comb begin
		frame_d.fld.start  = 1'b0;
		frame_d.fld.data   = i_tx_req.data;
		frame_d.fld.parity = calc_parity(i_tx_req.data);
		frame_d.fld.stop   = 1'b1;
	end

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			busy     <= 1'b0;
			bit_cnt  <= '0;
			o_serial <= 1'b1;                       // line idles high
		end else if (accept) begin
			busy    <= 1'b1;                        // ready drops next cycle
			bit_cnt <= '0;
		end else if (shift_en) begin
			if (bit_cnt == LAST_BIT) begin
				busy     <= 1'b0;                   // stop bit has lasted a full bit time
				o_serial <= 1'b1;
			end else begin
				o_serial <= shift_q.raw[0];         // start bit first
				bit_cnt  <= bit_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge i_tx_clk) begin
		if (accept) begin
			shift_q <= frame_d;
		end else if (shift_en) begin
			shift_q.raw <= {1'b1, shift_q.raw[`UART_FRAME_W-1:1]};    // fill with idle level
		end
	end

	// the line must be idle whenever a new byte can be taken
	a_idle_when_ready: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		o_tx_ready |-> o_serial);

endmodule

// ==== verilog/uart_rx.sv ====
`include "uart_macros.svh"

module uart_rx (
	input  logic                      i_tx_clk,
	input  logic                      i_reset_tx,
	input  logic                      i_sample_tick,
	input  logic                      i_serial,
	output logic                      o_rx_valid,
	output uart_host_pkg::rx_result_t o_rx_result
);

	import uart_frame_pkg::*;

	localparam int SYNC_W    = `UART_SYNC_STAGES;
	localparam int PHASE_W   = $clog2(`UART_SAMPLES_PER_BIT);
	localparam int BIT_IDX_W = $clog2(`UART_FRAME_W);
	localparam logic [PHASE_W-1:0] PHASE_MID = PHASE_W'(`UART_SAMPLES_PER_BIT / 2 - 1);
	localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`UART_SAMPLES_PER_BIT - 1);
	localparam logic [BIT_IDX_W-1:0] STOP_IDX = BIT_IDX_W'(`UART_FRAME_W - 1);

	logic [SYNC_W-1:0]    sync_q;                   // line synchronizer, oldest at msb
	logic                 line;                     // synchronized line level
	logic                 line_d;                   // previous level for edge detect
	logic                 start_edge;               // falling edge while idle
	logic                 busy;                     // inside a frame
	logic [PHASE_W-1:0]   phase;                    // sample ticks since bit start
	logic [BIT_IDX_W-1:0] bit_idx;                  // frame bit being sampled
	logic                 mid_sample;               // sample point of the current bit
	frame_t               shift_q;                  // bits sampled so far
	frame_t               frame_in;                 // frame including the current sample
	data_t                rx_data;

	assign line       = sync_q[SYNC_W-1];
	assign start_edge = line_d & ~line & ~busy;
	assign mid_sample = busy & i_sample_tick & (phase == PHASE_MID);
	assign frame_in.raw = {line, shift_q.raw[`UART_FRAME_W-1:1]};   // lsb first, so shift right
	assign rx_data    = frame_in.fld.data;

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			sync_q <= '1;                           // idle level, no false start
			line_d <= 1'b1;
		end else begin
			sync_q <= {sync_q[SYNC_W-2:0], i_serial};
			line_d <= line;
		end
	end

	always_ff @(posedge i_tx_clk) begin
		if (i_reset_tx) begin
			busy       <= 1'b0;
			phase      <= '0;
			bit_idx    <= '0;
			o_rx_valid <= 1'b0;
		end else begin
			o_rx_valid <= 1'b0;
			if (start_edge) begin
				busy    <= 1'b1;
				phase   <= '0;                      // realign bit timing to the edge
				bit_idx <= '0;
			end else if (busy && i_sample_tick) begin
				phase <= (phase == PHASE_LAST) ? '0 : phase + 1'b1;
				if (phase == PHASE_MID) begin
					if (bit_idx == '0 && line) begin
						busy <= 1'b0;               // start bit gone by mid-bit, glitch
					end else if (bit_idx == STOP_IDX) begin
						busy       <= 1'b0;         // back to idle with the result
						o_rx_valid <= 1'b1;
					end else begin
						bit_idx <= bit_idx + 1'b1;
					end
				end
			end
		end
	end

	always_ff @(posedge i_tx_clk) begin
		if (mid_sample) begin
			shift_q <= frame_in;
		end
		if (mid_sample && bit_idx == STOP_IDX) begin
			o_rx_result.data         <= rx_data;
			o_rx_result.parity_error <= (frame_in.fld.parity != calc_parity(rx_data));
			o_rx_result.frame_error  <= ~frame_in.fld.stop;
		end
	end

	// host has no back-pressure, each result is a single cycle
	a_valid_single: assert property (@(posedge i_tx_clk) disable iff (i_reset_tx)
		o_rx_valid |=> !o_rx_valid);

endmodule

// ==== verilog/uart_top.sv ====
module uart_top (
	input  logic                      tx_clk,
	input  logic                      reset_tx,
	input  logic                      i_tx_valid,
	input  uart_host_pkg::tx_req_t    i_tx_req,
	output logic                      o_tx_ready,
	input  logic                      i_loopback,
	input  logic                      i_rx_serial,
	output logic                      o_serial,
	output logic                      o_rx_valid,
	output uart_host_pkg::rx_result_t o_rx_result
);

	logic sample_tick;                              // 8 per bit time
	logic bit_tick;                                 // frame bit boundary
	logic tx_line;                                  // transmitter output
	logic rx_line;                                  // receiver input after loopback mux

	assign o_serial = tx_line;
	assign rx_line  = i_loopback ? tx_line : i_rx_serial;   // loopback ties tx to rx

	uart_baud_gen u_baud_gen (
		.i_tx_clk      (tx_clk),
		.i_reset_tx    (reset_tx),
		.o_sample_tick (sample_tick),
		.o_bit_tick    (bit_tick)
	);

	uart_tx u_tx (
		.i_tx_clk   (tx_clk),
		.i_reset_tx (reset_tx),
		.i_bit_tick (bit_tick),
		.i_tx_valid (i_tx_valid),
		.i_tx_req   (i_tx_req),
		.o_tx_ready (o_tx_ready),
		.o_serial   (tx_line)
	);

	uart_rx u_rx (
		.i_tx_clk      (tx_clk),
		.i_reset_tx    (reset_tx),
		.i_sample_tick (sample_tick),
		.i_serial      (rx_line),
		.o_rx_valid    (o_rx_valid),
		.o_rx_result   (o_rx_result)
	);

endmodule

// ==== verif/uart_tb.sv ====
`include "uart_macros.svh"

module uart_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import uart_frame_pkg::*;
	import uart_host_pkg::*;

	localparam int CLK_PERIOD   = 100;
	localparam int DRIVE_DELAY  = 10;              // inputs change this long after posedge
	localparam int RESET_CYCLES = 10;
	localparam int IDLE_CYCLES  = 20;              // quiet line check after reset
	localparam int BIT_CYCLES   = 16;              // 8 samples of 2 clocks each
	localparam int N_STIM       = 12;
	localparam int WATCHDOG_NS  = (N_STIM * 220 + RESET_CYCLES + IDLE_CYCLES) * CLK_PERIOD;

	typedef enum logic [1:0] {CORRUPT_NONE, CORRUPT_PARITY, CORRUPT_STOP} corrupt_e;

	typedef struct packed {
		data_t    data;                            // byte to send
		logic     loopback;                        // 1 = tx feeds rx
		corrupt_e corrupt;                         // only used on the external line
	} stim_t;

	stim_t stim_tbl [N_STIM] = '{
		'{8'h55, 1'b1, CORRUPT_NONE},
		'{8'hA3, 1'b1, CORRUPT_NONE},
		'{8'h00, 1'b1, CORRUPT_NONE},
		'{8'hFF, 1'b1, CORRUPT_NONE},
		'{8'h3C, 1'b0, CORRUPT_NONE},
		'{8'h81, 1'b0, CORRUPT_PARITY},
		'{8'h7E, 1'b0, CORRUPT_STOP},
		'{8'h96, 1'b1, CORRUPT_NONE},
		'{8'h01, 1'b0, CORRUPT_PARITY},
		'{8'hC5, 1'b0, CORRUPT_NONE},
		'{8'h80, 1'b1, CORRUPT_NONE},
		'{8'h5A, 1'b0, CORRUPT_STOP}
	};

	logic       tx_clk;
	logic       reset_tx;
	logic       i_tx_valid;
	tx_req_t    i_tx_req;
	logic       o_tx_ready;
	logic       i_loopback;
	logic       i_rx_serial;
	logic       o_serial;
	logic       o_rx_valid;
	rx_result_t o_rx_result;

	rx_result_t rx_q [$];                          // results caught by the monitor
	int         rx_count     = 0;                  // o_rx_valid pulses seen
	int         accept_count = 0;                  // requests taken by the DUT
	logic       ready_d      = 1'b1;               // o_tx_ready at the last falling edge

	uart_top uut (
		.tx_clk      (tx_clk),
		.reset_tx    (reset_tx),
		.i_tx_valid  (i_tx_valid),
		.i_tx_req    (i_tx_req),
		.o_tx_ready  (o_tx_ready),
		.i_loopback  (i_loopback),
		.i_rx_serial (i_rx_serial),
		.o_serial    (o_serial),
		.o_rx_valid  (o_rx_valid),
		.o_rx_result (o_rx_result)
	);

	initial begin
		tx_clk = 1'b0;
		forever #(CLK_PERIOD / 2) tx_clk = ~tx_clk;
	end

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			report_failure($sformatf("** Error %s expected %h got %h", name, exp, got));
		end
	endtask

	task automatic check_result(input string name, input rx_result_t exp, input rx_result_t got);
		if (got !== exp) begin
			report_failure($sformatf("** Error %s expected %h got %h", name, exp, got));
		end
	endtask

	task automatic next_cycle();
		@(posedge tx_clk);
		#DRIVE_DELAY;
	endtask

	// frame in line order with the start bit at bit 0
	function automatic logic [`UART_FRAME_W-1:0] build_frame(input data_t d, input corrupt_e c);
		logic par;
		logic stop;
		par  = (($countones(d) + `UART_PARITY_ODD) % 2) == 1;   // total ones even in even mode
		stop = (c != CORRUPT_STOP);
		if (c == CORRUPT_PARITY) begin
			par = ~par;
		end
		return {stop, par, d, 1'b0};
	endfunction

	task automatic take_result(input rx_result_t exp);
		rx_result_t got;
		while (rx_q.size() == 0) @(posedge tx_clk);   // wait for the monitor to catch a pulse
		got = rx_q.pop_front();
		check_result("o_rx_result", exp, got);
	endtask

	task automatic send_loopback(input data_t d);
		logic [`UART_FRAME_W-1:0] exp_frame;
		rx_result_t               exp_res;
		int                       i;
		exp_frame = build_frame(d, CORRUPT_NONE);
		exp_res   = '{data: d, parity_error: 1'b0, frame_error: 1'b0};
		i_tx_req.data = d;
		i_tx_valid    = 1'b1;                      // held until ready is seen
		@(negedge tx_clk);
		while (!o_tx_ready) @(negedge tx_clk);
		next_cycle();                              // handshake on the edge just passed
		i_tx_valid = 1'b0;
		@(negedge tx_clk);
		while (o_serial) begin
			check_bit("o_tx_ready", 1'b0, o_tx_ready);
			@(negedge tx_clk);
		end
		repeat (8) @(negedge tx_clk);             // middle of the start bit
		for (i = 0; i < `UART_FRAME_W; i++) begin
			if (i > 0) repeat (BIT_CYCLES) @(negedge tx_clk);
			check_bit($sformatf("o_serial[%0d]", i), exp_frame[i], o_serial);
			check_bit("o_tx_ready", 1'b0, o_tx_ready);
		end
		take_result(exp_res);
	endtask

	task automatic send_external(input data_t d, input corrupt_e c);
		logic [`UART_FRAME_W-1:0] frame;
		rx_result_t               exp_res;
		int                       i;
		frame   = build_frame(d, c);
		exp_res = '{data: d, parity_error: (c == CORRUPT_PARITY),
			frame_error: (c == CORRUPT_STOP)};
		for (i = 0; i < `UART_FRAME_W; i++) begin
			i_rx_serial = frame[i];
			repeat (BIT_CYCLES) next_cycle();
		end
		i_rx_serial = 1'b1;                        // back to idle
		take_result(exp_res);
	endtask

	// capture on the falling edge where all DUT outputs are settled
	always @(negedge tx_clk) begin
		if (!reset_tx) begin
			if (o_rx_valid) begin
				rx_q.push_back(o_rx_result);
				rx_count++;
			end
			if (ready_d && !o_tx_ready) begin
				accept_count++;                    // ready drops once per request taken
			end
			ready_d = o_tx_ready;
		end
	end

	initial begin
		#WATCHDOG_NS;
		report_failure("timeout: receive result never arrived");
	end

	initial begin
		int e;
		int gap;
		int n_loop;
		void'($urandom(3));
		n_loop      = 0;
		reset_tx    = 1'b1;
		i_tx_valid  = 1'b0;
		i_tx_req    = '0;
		i_loopback  = 1'b1;
		i_rx_serial = 1'b1;
		repeat (RESET_CYCLES) @(posedge tx_clk);
		#DRIVE_DELAY;
		reset_tx = 1'b0;
		repeat (IDLE_CYCLES) begin
			@(negedge tx_clk);
			check_bit("o_serial", 1'b1, o_serial);
			check_bit("o_tx_ready", 1'b1, o_tx_ready);
			check_bit("o_rx_valid", 1'b0, o_rx_valid);
		end
		next_cycle();
		for (e = 0; e < N_STIM; e++) begin
			gap = $urandom % 21;                   // 0 to 20 idle cycles
			repeat (gap) next_cycle();
			i_loopback = stim_tbl[e].loopback;     // both lines idle high here
			if (stim_tbl[e].loopback) begin
				send_loopback(stim_tbl[e].data);
				n_loop++;
			end else begin
				send_external(stim_tbl[e].data, stim_tbl[e].corrupt);
			end
			if (rx_q.size() != 0) report_failure("extra receive pulse after a frame");
		end
		repeat (3 * BIT_CYCLES) next_cycle();      // let the last frame drain
		if (rx_count != N_STIM || accept_count != n_loop || rx_q.size() != 0) begin
			report_failure("receive pulses or accepts do not match the frames sent");
		end else begin
			$display("No errors");
			$finish;
		end
	end

endmodule

// ==== src.f ====
+incdir+verilog
verilog/uart_frame_pkg.sv
verilog/uart_host_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_top.sv
verif/uart_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the UART testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f src.f \
	--top-module uart_tb \
	-o uart_sim

# a failing run ends in $fatal, which gives a nonzero exit status
./obj_dir/uart_sim
